// File: book_macros.svh
//====================
// Price book parameters
// Entry count, field widths, book side and APB register map
//====================
`ifndef BOOK_MACROS_SVH
`define BOOK_MACROS_SVH

// List geometry
`define BOOK_ENTRIES 8
`define BOOK_KEY_W 15
`define BOOK_VOL_W 16
`define BOOK_SIZE_W 4

// 1 for a bid book, 0 for an ask book
`define BOOK_IS_BID 1

// APB bus
`define BOOK_APB_AW 8
`define BOOK_APB_DW 32

// Register offsets with entry i at ENTRY0 + 4*i
`define BOOK_REG_KEY 8'h00
`define BOOK_REG_VOL 8'h04
`define BOOK_REG_CMD 8'h08
`define BOOK_REG_STATUS 8'h0C
`define BOOK_REG_ENTRY0 8'h10

`endif

// File: book_pkg.sv
//====================
// Price book types
// Opcodes, sequencer states and list field types
//====================
`include "book_macros.svh"

package book_pkg;

  // Host command from CMD write data bits 1:0
  typedef enum logic [1:0] {
    OP_CLEAR   = 2'd0,
    OP_ADD     = 2'd1,
    OP_DELETE  = 2'd2,
    OP_REPLACE = 2'd3
  } book_op_e;

  // Command sequencer
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_EXEC = 2'd1,
    ST_DONE = 2'd2
  } book_state_e;

  // Entry fields
  typedef logic [`BOOK_KEY_W-1:0] book_key_t;
  typedef logic [`BOOK_VOL_W-1:0] book_vol_t;
  typedef logic [`BOOK_SIZE_W-1:0] book_size_t;

  // One bit per entry with bit 0 at the head
  typedef logic [`BOOK_ENTRIES-1:0] book_mask_t;

endpackage

// File: book_state_if.sv
//====================
// Book list state bus
// Current entries and size, from the store to the readers
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

interface book_state_if
  import book_pkg::*;
();

  // Valid bits packed from index 0
  book_mask_t                       vld;
  book_key_t [`BOOK_ENTRIES-1:0]    keys;
  book_vol_t [`BOOK_ENTRIES-1:0]    volumes;
  // Number of valid entries
  book_size_t                       size;

  modport store (output vld, keys, volumes, size);
  modport reader (input vld, keys, volumes, size);

endinterface

// File: book_op_if.sv
//====================
// Book command bus
// Command under execution, from control to the datapath
//====================
`timescale 1ns/1ns

interface book_op_if
  import book_pkg::*;
();

  // One cycle strobe that writes the list state on its edge
  logic       go;
  book_op_e   op;
  book_key_t  key;
  book_vol_t  volume;

  modport ctrl (output go, op, key, volume);
  modport exec (input go, op, key, volume);

endinterface

// File: book_ctrl.sv
//====================
// Price book control
// APB slave, KEY/VOL registers, command sequencer and read mux
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

module book_ctrl
  import book_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  logic [`BOOK_APB_AW-1:0]  i_paddr,
  input  logic [`BOOK_APB_DW-1:0]  i_pwdata,
  output logic [`BOOK_APB_DW-1:0]  o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,
  book_op_if.ctrl                  op_bus,
  book_state_if.reader             state_bus
);

  localparam int IDX_W = $clog2(`BOOK_ENTRIES);

  logic                     access;
  logic                     addr_key;
  logic                     addr_vol;
  logic                     addr_cmd;
  logic                     addr_status;
  logic                     addr_entry;
  logic                     addr_ok;
  logic [`BOOK_APB_AW-1:0]  entry_off;
  logic [IDX_W-1:0]         entry_idx;
  logic                     op_bad;
  logic                     cmd_wr;
  logic                     cmd_run;
  logic                     full;
  book_state_e              state_r;
  book_state_e              state_nxt;
  book_key_t                key_r;
  book_vol_t                vol_r;
  book_op_e                 op_r;

  // Access phase of an APB transfer
  assign access = i_psel & i_penable;

  // Address decode
  assign addr_key    = (i_paddr == `BOOK_REG_KEY);
  assign addr_vol    = (i_paddr == `BOOK_REG_VOL);
  assign addr_cmd    = (i_paddr == `BOOK_REG_CMD);
  assign addr_status = (i_paddr == `BOOK_REG_STATUS);
  // Entry window is word aligned and inside the list only
  assign addr_entry  = (i_paddr >= `BOOK_REG_ENTRY0) &&
                       (i_paddr < `BOOK_REG_ENTRY0 + 4 * `BOOK_ENTRIES) &&
                       (i_paddr[1:0] == 2'b00);
  assign addr_ok     = addr_key | addr_vol | addr_cmd | addr_status | addr_entry;
  assign entry_off   = i_paddr - `BOOK_REG_ENTRY0;
  assign entry_idx   = entry_off[2 +: IDX_W];

  // Only opcodes 0 to 3 are defined
  assign op_bad  = (i_pwdata[`BOOK_APB_DW-1:2] != '0);
  assign cmd_wr  = access & i_pwrite & addr_cmd;
  assign cmd_run = cmd_wr & ~op_bad;

  // Valid commands stall until the sequencer reaches DONE
  assign o_pready  = access & (~cmd_run | (state_r == ST_DONE));
  assign o_pslverr = access & (~addr_ok | (cmd_wr & op_bad));

  // Sequencer steps from IDLE to EXEC to DONE over the access cycles
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: if (cmd_run) state_nxt = ST_EXEC;
      ST_EXEC: state_nxt = ST_DONE;
      ST_DONE: state_nxt = ST_IDLE;
      default: state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_r <= ST_IDLE;
      key_r   <= '0;
      vol_r   <= '0;
    end else begin
      state_r <= state_nxt;
      // Operand registers are written in the first access cycle
      if (access && i_pwrite && addr_key)
        key_r <= i_pwdata[`BOOK_KEY_W-1:0];
      if (access && i_pwrite && addr_vol)
        vol_r <= i_pwdata[`BOOK_VOL_W-1:0];
    end
  end

  // Opcode held for the EXEC cycle
  always_ff @(posedge i_clk) begin
    if ((state_r == ST_IDLE) && cmd_run)
      op_r <= book_op_e'(i_pwdata[1:0]);
  end

  // Command to the datapath
  assign op_bus.go     = (state_r == ST_EXEC);
  assign op_bus.op     = op_r;
  assign op_bus.key    = key_r;
  assign op_bus.volume = vol_r;

  assign full = (state_bus.size == `BOOK_ENTRIES);

  // Read mux
  always_comb begin
    o_prdata = '0;
    if (addr_key) begin
      o_prdata[`BOOK_KEY_W-1:0] = key_r;
    end else if (addr_vol) begin
      o_prdata[`BOOK_VOL_W-1:0] = vol_r;
    end else if (addr_status) begin
      // Size in the low bits and full flag in bit 8
      o_prdata[`BOOK_SIZE_W-1:0] = state_bus.size;
      o_prdata[8]                = full;
    end else if (addr_entry) begin
      o_prdata = {state_bus.vld[entry_idx],
                  state_bus.keys[entry_idx],
                  state_bus.volumes[entry_idx]};
    end
  end

endmodule

// File: book_locate.sv
//====================
// Price book search
// Key match and insertion point over all entries
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

module book_locate
  import book_pkg::*;
(
  book_state_if.reader  state_bus,
  book_op_if.exec       op_bus,
  output book_mask_t    o_match_sel,
  output book_mask_t    o_ins_sel,
  output logic          o_match_hit
);

  localparam bit IS_BID = (`BOOK_IS_BID != 0);

  book_mask_t key_eq;
  book_mask_t key_better;
  book_mask_t ge_mask;

  // Per entry compare against the command key
  always_comb begin
    for (int i = 0; i < `BOOK_ENTRIES; i++) begin
      key_eq[i] = (state_bus.keys[i] == op_bus.key);
      // Bid ranks higher keys first and ask ranks lower keys first
      if (IS_BID)
        key_better[i] = (state_bus.keys[i] > op_bus.key);
      else
        key_better[i] = (state_bus.keys[i] < op_bus.key);
    end
  end

  // Valid entries that stay ahead of the new key
  assign ge_mask = state_bus.vld & (key_eq | key_better);

  // First clear position from the head
  // All ones means the new key is worse than a full list
  assign o_ins_sel = ~ge_mask & (ge_mask + 1'b1);

  // Keys are unique, so at most one bit is set
  assign o_match_sel = state_bus.vld & key_eq;
  assign o_match_hit = |o_match_sel;

endmodule

// File: book_shift.sv
//====================
// Price book next state
// Insert, shift and replace over valid bits, keys and volumes
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

module book_shift
  import book_pkg::*;
(
  book_state_if.reader                  state_bus,
  book_op_if.exec                       op_bus,
  input  book_mask_t                    i_match_sel,
  input  book_mask_t                    i_ins_sel,
  input  logic                          i_match_hit,
  output book_mask_t                    o_vld_nxt,
  output book_key_t [`BOOK_ENTRIES-1:0] o_keys_nxt,
  output book_vol_t [`BOOK_ENTRIES-1:0] o_vols_nxt,
  output book_size_t                    o_size_nxt
);

  localparam int N = `BOOK_ENTRIES;

  logic               op_clr;
  logic               op_add;
  logic               op_del;
  logic               op_rep;
  logic               full;
  book_mask_t         ins_ge;
  book_mask_t         match_ge;
  book_mask_t         take_below;
  book_mask_t         take_above;
  book_mask_t         ins_key;
  book_mask_t         ins_vol;
  book_mask_t         vld_below;
  book_mask_t         vld_above;
  book_key_t [N-1:0]  keys_below;
  book_key_t [N-1:0]  keys_above;
  book_vol_t [N-1:0]  vols_below;
  book_vol_t [N-1:0]  vols_above;

  assign op_clr = (op_bus.op == OP_CLEAR);
  assign op_add = (op_bus.op == OP_ADD);
  assign op_del = (op_bus.op == OP_DELETE);
  assign op_rep = (op_bus.op == OP_REPLACE);
  assign full   = (state_bus.size == N);

  // Positions from the one-hot point upward and none for a zero vector
  assign ins_ge   = ~(i_ins_sel - 1'b1);
  assign match_ge = ~(i_match_sel - 1'b1);

  // ADD moves worse entries up one place and the top one falls off
  assign take_below = {N{op_add}} & (ins_ge << 1);
  // DELETE closes the gap from above
  assign take_above = {N{op_del}} & match_ge;

  // REPLACE writes the volume only
  assign ins_key = {N{op_add}} & i_ins_sel;
  assign ins_vol = {N{op_rep}} & i_match_sel;

  // Neighbor views where index i sees i-1 and i+1
  assign vld_below  = state_bus.vld << 1;
  assign vld_above  = state_bus.vld >> 1;
  assign keys_below = state_bus.keys << `BOOK_KEY_W;
  assign keys_above = state_bus.keys >> `BOOK_KEY_W;
  assign vols_below = state_bus.volumes << `BOOK_VOL_W;
  assign vols_above = state_bus.volumes >> `BOOK_VOL_W;

  // Per entry select among insert, from below, from above or keep
  always_comb begin
    for (int i = 0; i < N; i++) begin
      o_vld_nxt[i]  = state_bus.vld[i];
      o_keys_nxt[i] = state_bus.keys[i];
      o_vols_nxt[i] = state_bus.volumes[i];
      if (op_clr) begin
        o_vld_nxt[i] = 1'b0;
      end else if (ins_key[i]) begin
        o_vld_nxt[i]  = 1'b1;
        o_keys_nxt[i] = op_bus.key;
        o_vols_nxt[i] = op_bus.volume;
      end else if (ins_vol[i]) begin
        o_vols_nxt[i] = op_bus.volume;
      end else if (take_below[i]) begin
        o_vld_nxt[i]  = vld_below[i];
        o_keys_nxt[i] = keys_below[i];
        o_vols_nxt[i] = vols_below[i];
      end else if (take_above[i]) begin
        o_vld_nxt[i]  = vld_above[i];
        o_keys_nxt[i] = keys_above[i];
        o_vols_nxt[i] = vols_above[i];
      end
    end
  end

  // Size saturates at N on ADD
  always_comb begin
    o_size_nxt = state_bus.size;
    if (op_clr)
      o_size_nxt = '0;
    else if (op_add && !full)
      o_size_nxt = state_bus.size + 1'b1;
    else if (op_del && i_match_hit)
      o_size_nxt = state_bus.size - 1'b1;
  end

endmodule

// File: book_store.sv
//====================
// Price book store
// Registered entry list and list size
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

module book_store
  import book_pkg::*;
(
  input  logic                          i_clk,
  input  logic                          i_arst_n,
  input  logic                          i_go,
  input  book_mask_t                    i_vld_nxt,
  input  book_key_t [`BOOK_ENTRIES-1:0] i_keys_nxt,
  input  book_vol_t [`BOOK_ENTRIES-1:0] i_vols_nxt,
  input  book_size_t                    i_size_nxt,
  book_state_if.store                   state_bus
);

  book_mask_t                     vld_r;
  book_size_t                     size_r;
  book_key_t [`BOOK_ENTRIES-1:0]  keys_r;
  book_vol_t [`BOOK_ENTRIES-1:0]  vols_r;

  // Empty list out of reset
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      vld_r  <= '0;
      size_r <= '0;
    end else if (i_go) begin
      vld_r  <= i_vld_nxt;
      size_r <= i_size_nxt;
    end
  end

  // Entry payload qualified by vld_r
  always_ff @(posedge i_clk) begin
    if (i_go) begin
      keys_r <= i_keys_nxt;
      vols_r <= i_vols_nxt;
    end
  end

  assign state_bus.vld     = vld_r;
  assign state_bus.keys    = keys_r;
  assign state_bus.volumes = vols_r;
  assign state_bus.size    = size_r;

endmodule

// File: book_notify.sv
//====================
// Price book head notify
// Flags a head change and registers key and volume
//====================
`timescale 1ns/1ns

module book_notify
  import book_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_arst_n,
  book_state_if.reader  state_bus,
  book_op_if.exec       op_bus,
  input  book_mask_t    i_match_sel,
  input  book_mask_t    i_ins_sel,
  output logic          o_notify_vld,
  output book_key_t     o_notify_key,
  output book_vol_t     o_notify_volume
);

  logic       head_clr;
  logic       head_add;
  logic       head_del;
  logic       head_rep;
  logic       head_chg;
  book_vol_t  head_vol;

  // Head change cases
  assign head_clr = (op_bus.op == OP_CLEAR) & state_bus.vld[0];
  assign head_add = (op_bus.op == OP_ADD) & i_ins_sel[0];
  assign head_del = (op_bus.op == OP_DELETE) & i_match_sel[0];
  assign head_rep = (op_bus.op == OP_REPLACE) & i_match_sel[0];
  assign head_chg = head_clr | head_add | head_del | head_rep;

  // New volume on ADD/REPLACE, removed one on DELETE, zero on CLEAR
  assign head_vol = (head_add | head_rep) ? op_bus.volume :
                    head_del ? state_bus.volumes[0] : '0;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n)
      o_notify_vld <= 1'b0;
    else
      o_notify_vld <= op_bus.go & head_chg;
  end

  always_ff @(posedge i_clk) begin
    if (op_bus.go && head_chg) begin
      o_notify_key    <= op_bus.key;
      o_notify_volume <= head_vol;
    end
  end

endmodule

// File: price_book.sv
//====================
// Price book top
// Sorted price-level book behind an APB slave
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

module price_book
  import book_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  logic [`BOOK_APB_AW-1:0]  i_paddr,
  input  logic [`BOOK_APB_DW-1:0]  i_pwdata,
  output logic [`BOOK_APB_DW-1:0]  o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,
  output logic                     o_notify_vld,
  output book_key_t                o_notify_key,
  output book_vol_t                o_notify_volume
);

  book_mask_t                     match_sel;
  book_mask_t                     ins_sel;
  logic                           match_hit;
  book_mask_t                     vld_nxt;
  book_key_t [`BOOK_ENTRIES-1:0]  keys_nxt;
  book_vol_t [`BOOK_ENTRIES-1:0]  vols_nxt;
  book_size_t                     size_nxt;

  book_state_if state_if ();
  book_op_if    op_if ();

  // Host side
  book_ctrl u_ctrl (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .op_bus    (op_if.ctrl),
    .state_bus (state_if.reader)
  );

  // Search
  book_locate u_locate (
    .state_bus   (state_if.reader),
    .op_bus      (op_if.exec),
    .o_match_sel (match_sel),
    .o_ins_sel   (ins_sel),
    .o_match_hit (match_hit)
  );

  // Next state
  book_shift u_shift (
    .state_bus   (state_if.reader),
    .op_bus      (op_if.exec),
    .i_match_sel (match_sel),
    .i_ins_sel   (ins_sel),
    .i_match_hit (match_hit),
    .o_vld_nxt   (vld_nxt),
    .o_keys_nxt  (keys_nxt),
    .o_vols_nxt  (vols_nxt),
    .o_size_nxt  (size_nxt)
  );

  // List registers, written on go
  book_store u_store (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_go       (op_if.go),
    .i_vld_nxt  (vld_nxt),
    .i_keys_nxt (keys_nxt),
    .i_vols_nxt (vols_nxt),
    .i_size_nxt (size_nxt),
    .state_bus  (state_if.store)
  );

  book_notify u_notify (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .state_bus       (state_if.reader),
    .op_bus          (op_if.exec),
    .i_match_sel     (match_sel),
    .i_ins_sel       (ins_sel),
    .o_notify_vld    (o_notify_vld),
    .o_notify_key    (o_notify_key),
    .o_notify_volume (o_notify_volume)
  );

endmodule

// File: tb_price_book.sv
//====================
// Price book testbench
// Drives APB commands, checks entries, status and head
// notifications against a sorted-list reference model
//====================
`timescale 1ns/1ns
`include "book_macros.svh"

module tb_price_book
  import book_pkg::*;
();

  localparam int N = `BOOK_ENTRIES;

  logic                     i_clk;
  logic                     i_arst_n;
  logic                     i_psel;
  logic                     i_penable;
  logic                     i_pwrite;
  logic [`BOOK_APB_AW-1:0]  i_paddr;
  logic [`BOOK_APB_DW-1:0]  i_pwdata;
  logic [`BOOK_APB_DW-1:0]  o_prdata;
  logic                     o_pready;
  logic                     o_pslverr;
  logic                     o_notify_vld;
  book_key_t                o_notify_key;
  book_vol_t                o_notify_volume;

  // Reference list with the head at index 0
  book_key_t  m_key [N];
  book_vol_t  m_vol [N];
  int         m_size;
  // Pending head notifications
  book_key_t  exp_key_q[$];
  book_vol_t  exp_vol_q[$];

  integer     seed = 32'h815a_20d6;
  int         n_mismatch;
  int         n_other;
  int         cycle_cnt;
  int         xfer_cnt;

  price_book uut (
    .i_clk           (i_clk),
    .i_arst_n        (i_arst_n),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_paddr         (i_paddr),
    .i_pwdata        (i_pwdata),
    .o_prdata        (o_prdata),
    .o_pready        (o_pready),
    .o_pslverr       (o_pslverr),
    .o_notify_vld    (o_notify_vld),
    .o_notify_key    (o_notify_key),
    .o_notify_volume (o_notify_volume)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
      n_mismatch++;
    end
  endtask

  // One APB transfer with setup then access until ready
  task automatic apb_xfer(input bit wr, input logic [`BOOK_APB_AW-1:0] addr,
                          input logic [31:0] data, output logic [31:0] rdata,
                          output logic err, output int cycles);
    logic ready;
    xfer_cnt++;
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= wr;
    i_paddr   <= addr;
    i_pwdata  <= data;
    @(posedge i_clk);
    i_penable <= 1'b1;
    cycles = 0;
    ready  = 1'b0;
    // Sample mid cycle between driving edges
    while (!ready) begin
      @(negedge i_clk);
      cycles++;
      ready = o_pready;
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic write_reg(input logic [`BOOK_APB_AW-1:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    int          cyc;
    apb_xfer(1'b1, addr, data, rd, err, cyc);
    check_val("o_pslverr", err, 32'd0);
  endtask

  // Bid keeps higher keys ahead and ask keeps lower keys ahead
  function automatic bit ranks_ahead(input book_key_t have, input book_key_t key);
    if (`BOOK_IS_BID != 0)
      return have >= key;
    return have <= key;
  endfunction

  function automatic bit in_book(input book_key_t key);
    for (int i = 0; i < m_size; i++)
      if (m_key[i] == key)
        return 1'b1;
    return 1'b0;
  endfunction

  // Applies one command to the model and returns the head notification
  function automatic bit ref_apply(input book_op_e op, input book_key_t key,
                                   input book_vol_t vol, output book_key_t n_key,
                                   output book_vol_t n_vol);
    int pos;
    int hit;
    bit notify;
    notify = 1'b0;
    n_key  = key;
    n_vol  = vol;
    hit    = -1;
    for (int i = 0; i < m_size; i++)
      if (m_key[i] == key)
        hit = i;
    case (op)
      OP_CLEAR: begin
        notify = (m_size > 0);
        n_vol  = '0;
        m_size = 0;
      end
      OP_ADD: begin
        pos = 0;
        while (pos < m_size && ranks_ahead(m_key[pos], key))
          pos++;
        // Worse than a full list means nothing to insert
        if (pos < N) begin
          for (int i = N - 1; i > pos; i--) begin
            m_key[i] = m_key[i-1];
            m_vol[i] = m_vol[i-1];
          end
          m_key[pos] = key;
          m_vol[pos] = vol;
          if (m_size < N)
            m_size++;
          notify = (pos == 0);
        end
      end
      OP_DELETE: begin
        if (hit >= 0) begin
          n_vol = m_vol[hit];
          for (int i = hit; i < N - 1; i++) begin
            m_key[i] = m_key[i+1];
            m_vol[i] = m_vol[i+1];
          end
          m_size--;
          notify = (hit == 0);
        end
      end
      default: begin
        if (hit >= 0) begin
          m_vol[hit] = vol;
          notify = (hit == 0);
        end
      end
    endcase
    return notify;
  endfunction

  // Status word and every entry against the model
  task automatic check_book();
    logic [31:0] rd;
    logic [31:0] exp;
    logic        err;
    int          cyc;
    exp = m_size;
    exp[8] = (m_size == N);
    apb_xfer(1'b0, `BOOK_REG_STATUS, 32'd0, rd, err, cyc);
    check_val("o_pslverr", err, 32'd0);
    check_val("STATUS", rd, exp);
    for (int i = 0; i < N; i++) begin
      apb_xfer(1'b0, `BOOK_REG_ENTRY0 + 4 * i, 32'd0, rd, err, cyc);
      check_val("o_pslverr", err, 32'd0);
      // Payload of an empty slot is left unchecked
      if (i < m_size)
        check_val($sformatf("ENTRY%0d", i), rd, {1'b1, m_key[i], m_vol[i]});
      else
        check_val($sformatf("ENTRY%0d valid", i), rd[31], 32'd0);
    end
  endtask

  task automatic run_cmd(input book_op_e op, input book_key_t key, input book_vol_t vol);
    logic [31:0] rd;
    logic        err;
    int          cyc;
    book_key_t   nk;
    book_vol_t   nv;
    write_reg(`BOOK_REG_KEY, key);
    write_reg(`BOOK_REG_VOL, vol);
    if (ref_apply(op, key, vol, nk, nv)) begin
      exp_key_q.push_back(nk);
      exp_vol_q.push_back(nv);
    end
    apb_xfer(1'b1, `BOOK_REG_CMD, {30'd0, op}, rd, err, cyc);
    check_val("o_pslverr", err, 32'd0);
    assert (cyc == 3) else begin
      $display("Command %s took %0d access cycles instead of 3", op.name(), cyc);
      n_other++;
    end
    assert (exp_key_q.size() == 0) else begin
      $display("Head notification missing after %s of key 0x%h", op.name(), key);
      n_other++;
      exp_key_q.delete();
      exp_vol_q.delete();
    end
    check_book();
  endtask

  task automatic rand_key(output book_key_t k);
    logic [31:0] r;
    r = $random(seed);
    k = r[`BOOK_KEY_W-1:0];
    while (in_book(k)) begin
      r = $random(seed);
      k = r[`BOOK_KEY_W-1:0];
    end
  endtask

  // Notification monitor sampling every cycle
  initial begin : notify_mon
    forever begin
      @(negedge i_clk);
      if (o_notify_vld !== 1'b0) begin
        assert (exp_key_q.size() != 0) else begin
          $display("Head notification with key 0x%h when none was due", o_notify_key);
          n_other++;
        end
        if (exp_key_q.size() != 0) begin
          check_val("o_notify_key", o_notify_key, exp_key_q.pop_front());
          check_val("o_notify_volume", o_notify_volume, exp_vol_q.pop_front());
        end
      end
    end
  end

  // Run limit grows with the APB traffic issued
  initial begin : watchdog
    while (cycle_cnt <= 40 * xfer_cnt + 200) begin
      @(posedge i_clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles with %0d APB transfers", cycle_cnt, xfer_cnt);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    logic [31:0] rd;
    logic        err;
    int          cyc;
    book_key_t   k;
    logic [31:0] r;
    i_arst_n  = 1'b0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    m_size    = 0;
    repeat (3) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(negedge i_clk);
    check_val("o_pready", o_pready, 32'd0);
    check_val("o_pslverr", o_pslverr, 32'd0);
    check_book();

    // Fill past the end with unique random keys
    for (int n = 0; n < N + 6; n++) begin
      rand_key(k);
      r = $random(seed);
      run_cmd(OP_ADD, k, r[15:0]);
    end
    // Worst possible key falls off a full book
    k = (`BOOK_IS_BID != 0) ? '0 : '1;
    if (!in_book(k))
      run_cmd(OP_ADD, k, 16'h0bad);

    // Middle, absent and head deletes
    run_cmd(OP_DELETE, m_key[3], 16'h0);
    rand_key(k);
    run_cmd(OP_DELETE, k, 16'h0);
    run_cmd(OP_DELETE, m_key[0], 16'h0);

    // Replace below the head, at the head and on a miss
    run_cmd(OP_REPLACE, m_key[2], 16'h1234);
    run_cmd(OP_REPLACE, m_key[0], 16'hbeef);
    rand_key(k);
    run_cmd(OP_REPLACE, k, 16'h5555);

    // Undefined opcode is refused in one cycle
    apb_xfer(1'b1, `BOOK_REG_CMD, 32'h4, rd, err, cyc);
    check_val("o_pslverr", err, 32'd1);
    assert (cyc == 1) else begin
      $display("Undefined opcode took %0d access cycles instead of 1", cyc);
      n_other++;
    end
    // Entry past the list and an unmapped offset
    apb_xfer(1'b0, `BOOK_REG_ENTRY0 + 4 * N, 32'd0, rd, err, cyc);
    check_val("o_pslverr", err, 32'd1);
    apb_xfer(1'b0, 8'hfc, 32'd0, rd, err, cyc);
    check_val("o_pslverr", err, 32'd1);
    check_book();

    // Clear a filled book and then an empty one
    run_cmd(OP_CLEAR, 15'h0, 16'h0);
    run_cmd(OP_CLEAR, 15'h0, 16'h0);
    rand_key(k);
    run_cmd(OP_ADD, k, 16'h00aa);

    repeat (2) @(posedge i_clk);
    $display("Checks done: %0d mismatches, %0d other errors", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+.
book_pkg.sv
book_state_if.sv
book_op_if.sv
book_ctrl.sv
book_locate.sv
book_shift.sv
book_store.sv
book_notify.sv
price_book.sv
tb_price_book.sv

// File: Bender.yml
package:
  name: price_book

export_include_dirs:
  - .

sources:
  - files:
      - book_pkg.sv
      - book_state_if.sv
      - book_op_if.sv
      - book_ctrl.sv
      - book_locate.sv
      - book_shift.sv
      - book_store.sv
      - book_notify.sv
      - price_book.sv
  - target: test
    files:
      - tb_price_book.sv
